//--- common/ycr_intf_pkg.sv
//--------------------
// Data memory port widths and encodings
// Command, access width and response enums
//--------------------

package ycr_intf_pkg;

   //--------------------
   // Bus widths
   //--------------------
   localparam int YCR_DMEM_AWIDTH = 32;   // Core data address
   localparam int YCR_DMEM_DWIDTH = 32;   // Core data word
   localparam int YCR_WB_WIDTH    = 32;   // Wishbone address and data
   localparam int YCR_WB_SEL_W    = 4;    // Byte lanes on Wishbone

   //--------------------
   // Core request encodings
   //--------------------
   typedef enum logic {
      MEM_CMD_RD = 1'b0,                  // Load
      MEM_CMD_WR = 1'b1                   // Store
   } ycr_mem_cmd_e;

   typedef enum logic [1:0] {
      MEM_WIDTH_BYTE  = 2'b00,            // 8 bit access
      MEM_WIDTH_HWORD = 2'b01,            // 16 bit access
      MEM_WIDTH_WORD  = 2'b10             // 32 bit access
   } ycr_mem_width_e;

   //--------------------
   // Core response encoding
   //--------------------
   // Only the two RDY codes are ever pulsed back to the core,
   // NOTRDY is the idle value of the response lines
   typedef enum logic [1:0] {
      MEM_RESP_NOTRDY = 2'b00,            // No response this cycle
      MEM_RESP_RDY_OK = 2'b01,            // Done, data valid on reads
      MEM_RESP_RDY_ER = 2'b10             // Misaligned or bus error
   } ycr_mem_resp_e;

endpackage : ycr_intf_pkg

//--- dmem_wb/ycr_dmem_cmd_fifo.sv
`timescale 1ns/1ps
//--------------------
// Data memory request queue
// Circular buffer with occupancy count
//--------------------

module ycr_dmem_cmd_fifo
   import ycr_intf_pkg::*;
#(
   parameter int CMD_DEPTH = 4                        // Entries, power of two
) (
   input  logic                        clk_i,         // Core clock
   input  logic                        rst_i,         // Sync reset, active high

   // Core side
   input  logic                        req_i,         // Request level
   input  ycr_mem_cmd_e                cmd_i,         // Read or write
   input  ycr_mem_width_e              width_i,       // Access width
   input  logic [YCR_DMEM_AWIDTH-1:0]  addr_i,        // Byte address
   input  logic [YCR_DMEM_DWIDTH-1:0]  wdata_i,       // Store data
   output logic                        req_ack_o,     // Not full

   // Bus side
   input  logic                        pop_i,         // Head consumed
   output logic                        valid_o,       // Head present
   output ycr_mem_cmd_e                cmd_o,
   output ycr_mem_width_e              width_o,
   output logic [YCR_DMEM_AWIDTH-1:0]  addr_o,
   output logic [YCR_DMEM_DWIDTH-1:0]  wdata_o
);

   localparam int PTR_W = $clog2(CMD_DEPTH);          // Slot index
   localparam int CNT_W = PTR_W + 1;                  // Holds 0..CMD_DEPTH
   localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(CMD_DEPTH);

   //--------------------
   // Storage
   //--------------------
   ycr_mem_cmd_e               cmd_mem   [CMD_DEPTH];
   ycr_mem_width_e             width_mem [CMD_DEPTH];
   logic [YCR_DMEM_AWIDTH-1:0] addr_mem  [CMD_DEPTH];
   logic [YCR_DMEM_DWIDTH-1:0] wdata_mem [CMD_DEPTH];

   logic [PTR_W-1:0] wr_ptr_q;                        // Next free slot
   logic [PTR_W-1:0] rd_ptr_q;                        // Oldest entry
   logic [CNT_W-1:0] count_q;                         // Occupancy
   logic             full;
   logic             push;
   logic             pop;

   assign full      = (count_q == FULL_CNT);
   assign req_ack_o = ~full;                          // Combinational ack
   assign push      = req_i & ~full;                  // Acceptance cycle
   assign pop       = pop_i & valid_o;                // Ignore pop when empty

   // Payload write into the free slot
   always_ff @(posedge clk_i) begin
      if (push) begin
         cmd_mem[wr_ptr_q]   <= cmd_i;
         width_mem[wr_ptr_q] <= width_i;
         addr_mem[wr_ptr_q]  <= addr_i;
         wdata_mem[wr_ptr_q] <= wdata_i;
      end
   end

   // Pointers wrap at the power of two depth
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;   // Fill
            2'b01:   count_q <= count_q - 1'b1;   // Drain
            default: count_q <= count_q;          // Both or none
         endcase
      end
   end

   //--------------------
   // Head entry
   //--------------------
   assign valid_o = (count_q != '0);
   assign cmd_o   = cmd_mem[rd_ptr_q];
   assign width_o = width_mem[rd_ptr_q];
   assign addr_o  = addr_mem[rd_ptr_q];
   assign wdata_o = wdata_mem[rd_ptr_q];

endmodule : ycr_dmem_cmd_fifo

//--- dmem_wb/ycr_dmem_wb_master.sv
`timescale 1ns/1ps
//--------------------
// Wishbone master for data memory requests
// Lane select, alignment check, response pulse
//--------------------

module ycr_dmem_wb_master
   import ycr_intf_pkg::*;
(
   input  logic                        clk_i,          // Core clock
   input  logic                        rst_i,          // Sync reset, active high

   // FIFO head
   input  logic                        valid_i,        // Entry waiting
   input  ycr_mem_cmd_e                cmd_i,          // Read or write
   input  ycr_mem_width_e              width_i,        // Access width
   input  logic [YCR_DMEM_AWIDTH-1:0]  addr_i,         // Byte address
   input  logic [YCR_DMEM_DWIDTH-1:0]  wdata_i,        // Store data
   output logic                        pop_o,          // Take head entry

   // Core response
   output ycr_mem_resp_e               resp_o,         // One cycle pulse
   output logic [YCR_DMEM_DWIDTH-1:0]  rdata_o,        // Raw bus word

   // Wishbone
   output logic                        wbd_dmem_stb_o,
   output logic                        wbd_dmem_cyc_o,
   output logic [YCR_WB_WIDTH-1:0]     wbd_dmem_adr_o,
   output logic                        wbd_dmem_we_o,
   output logic [YCR_WB_WIDTH-1:0]     wbd_dmem_dat_o,
   output logic [YCR_WB_SEL_W-1:0]     wbd_dmem_sel_o,
   input  logic [YCR_WB_WIDTH-1:0]     wbd_dmem_dat_i,
   input  logic                        wbd_dmem_ack_i,
   input  logic                        wbd_dmem_err_i
);

   typedef enum logic [1:0] {
      IDLE = 2'b00,                                    // Wait for head entry
      BUS  = 2'b01,                                    // Cycle on Wishbone
      RESP = 2'b10                                     // Pulse response
   } state_e;

   state_e state_q;
   state_e state_d;

   logic                       misalign;               // Head entry illegal
   logic [YCR_WB_SEL_W-1:0]    sel_nxt;                // Lanes for head entry
   logic [YCR_WB_WIDTH-1:0]    dat_nxt;                // Replicated store data
   logic                       bus_done;               // Ack or err seen
   logic                       err_q;                  // Response is an error

   logic [YCR_WB_WIDTH-1:0]    adr_q;
   logic [YCR_WB_SEL_W-1:0]    sel_q;
   logic [YCR_WB_WIDTH-1:0]    dat_q;
   logic                       we_q;
   logic [YCR_DMEM_DWIDTH-1:0] rdata_q;

   //--------------------
   // Lane decode
   //--------------------
   // Narrow stores put the same bytes on every lane, so the slave
   // picks them up from whichever lanes sel enables
   always_comb begin
      sel_nxt  = '1;
      dat_nxt  = wdata_i;
      misalign = 1'b0;
      case (width_i)
         MEM_WIDTH_BYTE: begin
            sel_nxt = YCR_WB_SEL_W'(1) << addr_i[1:0];     // One lane
            dat_nxt = {4{wdata_i[7:0]}};
         end
         MEM_WIDTH_HWORD: begin
            sel_nxt  = addr_i[1] ? 4'b1100 : 4'b0011;      // Upper or lower half
            dat_nxt  = {2{wdata_i[15:0]}};
            misalign = addr_i[0];                          // Odd address
         end
         MEM_WIDTH_WORD: begin
            misalign = |addr_i[1:0];                       // Must be word aligned
         end
         default: begin
            misalign = 1'b1;                               // Unknown width
         end
      endcase
   end

   assign pop_o    = (state_q == IDLE) & valid_i;
   assign bus_done = wbd_dmem_ack_i | wbd_dmem_err_i;

   //--------------------
   // FSM
   //--------------------
   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (valid_i) begin
               state_d = misalign ? RESP : BUS;    // Misaligned skips the bus
            end
         end
         BUS: begin
            if (bus_done) begin
               state_d = RESP;
            end
         end
         RESP:    state_d = IDLE;                  // Single pulse
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= IDLE;
         err_q   <= 1'b0;
      end else begin
         state_q <= state_d;
         if (pop_o) begin
            err_q <= misalign;                     // Early error
         end else if ((state_q == BUS) && bus_done) begin
            err_q <= wbd_dmem_err_i;               // Slave error
         end
      end
   end

   // Bus fields held for the whole cycle
   always_ff @(posedge clk_i) begin
      if (pop_o && !misalign) begin
         adr_q <= {addr_i[YCR_WB_WIDTH-1:2], 2'b00};
         sel_q <= sel_nxt;
         dat_q <= dat_nxt;
         we_q  <= (cmd_i == MEM_CMD_WR);
      end
      if ((state_q == BUS) && wbd_dmem_ack_i) begin
         rdata_q <= wbd_dmem_dat_i;                // Read data capture
      end
   end

   //--------------------
   // Outputs
   //--------------------
   assign wbd_dmem_stb_o = (state_q == BUS);
   assign wbd_dmem_cyc_o = wbd_dmem_stb_o;         // No locked cycles
   assign wbd_dmem_adr_o = adr_q;
   assign wbd_dmem_sel_o = sel_q;
   assign wbd_dmem_dat_o = dat_q;
   assign wbd_dmem_we_o  = we_q;
   assign rdata_o        = rdata_q;

   always_comb begin
      if (state_q == RESP) begin
         resp_o = err_q ? MEM_RESP_RDY_ER : MEM_RESP_RDY_OK;
      end else begin
         resp_o = MEM_RESP_NOTRDY;
      end
   end

endmodule : ycr_dmem_wb_master

//--- src/ycr_intf.sv
`timescale 1ns/1ps
//--------------------
// Data memory interface top level
// Command FIFO in front of the Wishbone master
//--------------------

module ycr_intf
   import ycr_intf_pkg::*;
#(
   parameter int CMD_DEPTH = 4                              // Request queue depth
) (
   input  logic                        core_clk_i,          // Core clock
   input  logic                        rst_i,               // Sync reset, active high

   // Core data memory port
   input  logic                        core_dmem_req_i,     // Request level
   input  ycr_mem_cmd_e                core_dmem_cmd_i,     // Read or write
   input  ycr_mem_width_e              core_dmem_width_i,   // Access width
   input  logic [YCR_DMEM_AWIDTH-1:0]  core_dmem_addr_i,    // Byte address
   input  logic [YCR_DMEM_DWIDTH-1:0]  core_dmem_wdata_i,   // Store data
   output logic                        core_dmem_req_ack_o, // Request taken
   output logic [YCR_DMEM_DWIDTH-1:0]  core_dmem_rdata_o,   // Load data
   output ycr_mem_resp_e               core_dmem_resp_o,    // Response pulse

   // Wishbone master port
   output logic                        wbd_dmem_stb_o,      // Strobe
   output logic                        wbd_dmem_cyc_o,      // Cycle follows strobe
   output logic [YCR_WB_WIDTH-1:0]     wbd_dmem_adr_o,      // Word address
   output logic                        wbd_dmem_we_o,       // Write enable
   output logic [YCR_WB_WIDTH-1:0]     wbd_dmem_dat_o,      // Write data
   output logic [YCR_WB_SEL_W-1:0]     wbd_dmem_sel_o,      // Byte enables
   input  logic [YCR_WB_WIDTH-1:0]     wbd_dmem_dat_i,      // Read data
   input  logic                        wbd_dmem_ack_i,      // Cycle done
   input  logic                        wbd_dmem_err_i       // Cycle failed
);

   //--------------------
   // FIFO head to master
   //--------------------
   logic                       fifo_valid;                  // Head entry present
   logic                       fifo_pop;                    // Head taken by master
   ycr_mem_cmd_e               fifo_cmd;
   ycr_mem_width_e             fifo_width;
   logic [YCR_DMEM_AWIDTH-1:0] fifo_addr;
   logic [YCR_DMEM_DWIDTH-1:0] fifo_wdata;

   // Queue of requests in flight
   ycr_dmem_cmd_fifo #(
      .CMD_DEPTH  (CMD_DEPTH)
   ) i_cmd_fifo (
      .clk_i      (core_clk_i),
      .rst_i      (rst_i),
      .req_i      (core_dmem_req_i),
      .cmd_i      (core_dmem_cmd_i),
      .width_i    (core_dmem_width_i),
      .addr_i     (core_dmem_addr_i),
      .wdata_i    (core_dmem_wdata_i),
      .req_ack_o  (core_dmem_req_ack_o),
      .pop_i      (fifo_pop),
      .valid_o    (fifo_valid),
      .cmd_o      (fifo_cmd),
      .width_o    (fifo_width),
      .addr_o     (fifo_addr),
      .wdata_o    (fifo_wdata)
   );

   // One single-beat bus cycle per entry
   ycr_dmem_wb_master i_wb_master (
      .clk_i           (core_clk_i),
      .rst_i           (rst_i),
      .valid_i         (fifo_valid),
      .cmd_i           (fifo_cmd),
      .width_i         (fifo_width),
      .addr_i          (fifo_addr),
      .wdata_i         (fifo_wdata),
      .pop_o           (fifo_pop),
      .resp_o          (core_dmem_resp_o),
      .rdata_o         (core_dmem_rdata_o),
      .wbd_dmem_stb_o  (wbd_dmem_stb_o),
      .wbd_dmem_cyc_o  (wbd_dmem_cyc_o),
      .wbd_dmem_adr_o  (wbd_dmem_adr_o),
      .wbd_dmem_we_o   (wbd_dmem_we_o),
      .wbd_dmem_dat_o  (wbd_dmem_dat_o),
      .wbd_dmem_sel_o  (wbd_dmem_sel_o),
      .wbd_dmem_dat_i  (wbd_dmem_dat_i),
      .wbd_dmem_ack_i  (wbd_dmem_ack_i),
      .wbd_dmem_err_i  (wbd_dmem_err_i)
   );

endmodule : ycr_intf

//--- testbench/ycr_intf_chk.sv
`timescale 1ns/1ps
//--------------------
// Wishbone and response protocol assertions
// Bound to the bridge top level
//--------------------

module ycr_intf_chk
   import ycr_intf_pkg::*;
(
   input logic                    core_clk_i,
   input logic                    rst_i,
   input logic                    core_dmem_req_ack_o,
   input ycr_mem_resp_e           core_dmem_resp_o,
   input logic                    wbd_dmem_stb_o,
   input logic                    wbd_dmem_cyc_o,
   input logic [YCR_WB_WIDTH-1:0] wbd_dmem_adr_o,
   input logic                    wbd_dmem_we_o,
   input logic [YCR_WB_WIDTH-1:0] wbd_dmem_dat_o,
   input logic [YCR_WB_SEL_W-1:0] wbd_dmem_sel_o,
   input logic                    wbd_dmem_ack_i,
   input logic                    wbd_dmem_err_i
);

   int   fail_cnt = 0;                           // Failed assertions so far
   logic bus_done;

   assign bus_done = wbd_dmem_ack_i | wbd_dmem_err_i;

   // Strobe and fields held until the slave answers
   a_stb_hold: assert property (@(posedge core_clk_i) disable iff (rst_i)
      wbd_dmem_stb_o && !bus_done |=> wbd_dmem_stb_o &&
         $stable({wbd_dmem_adr_o, wbd_dmem_we_o, wbd_dmem_dat_o, wbd_dmem_sel_o}))
      else begin
         fail_cnt++;
         $error("stb or its fields changed before ack or err");
      end

   a_stb_drop: assert property (@(posedge core_clk_i) disable iff (rst_i)
      wbd_dmem_stb_o && bus_done |=> !wbd_dmem_stb_o)           // Single beat
      else begin
         fail_cnt++;
         $error("stb still high after ack or err");
      end

   a_cyc_eq_stb: assert property (@(posedge core_clk_i) disable iff (rst_i)
      wbd_dmem_cyc_o == wbd_dmem_stb_o)
      else begin
         fail_cnt++;
         $error("cyc differs from stb");
      end

   a_resp_pulse: assert property (@(posedge core_clk_i) disable iff (rst_i)
      core_dmem_resp_o != MEM_RESP_NOTRDY |=> core_dmem_resp_o == MEM_RESP_NOTRDY)
      else begin
         fail_cnt++;
         $error("response lasted more than one cycle");
      end

   // Idle state right after a reset cycle
   a_reset_state: assert property (@(posedge core_clk_i)
      rst_i |=> !wbd_dmem_stb_o && core_dmem_req_ack_o &&
         core_dmem_resp_o == MEM_RESP_NOTRDY)
      else begin
         fail_cnt++;
         $error("outputs not idle after reset");
      end

endmodule : ycr_intf_chk

bind ycr_intf ycr_intf_chk i_chk (
   .core_clk_i          (core_clk_i),
   .rst_i               (rst_i),
   .core_dmem_req_ack_o (core_dmem_req_ack_o),
   .core_dmem_resp_o    (core_dmem_resp_o),
   .wbd_dmem_stb_o      (wbd_dmem_stb_o),
   .wbd_dmem_cyc_o      (wbd_dmem_cyc_o),
   .wbd_dmem_adr_o      (wbd_dmem_adr_o),
   .wbd_dmem_we_o       (wbd_dmem_we_o),
   .wbd_dmem_dat_o      (wbd_dmem_dat_o),
   .wbd_dmem_sel_o      (wbd_dmem_sel_o),
   .wbd_dmem_ack_i      (wbd_dmem_ack_i),
   .wbd_dmem_err_i      (wbd_dmem_err_i)
);

//--- testbench/tb_ycr_intf.sv
`timescale 1ns/1ps
//--------------------
// Testbench for the data memory bridge
// Wishbone slave model, scoreboard, directed tests
//--------------------

module tb_ycr_intf
   import ycr_intf_pkg::*;
();

   localparam int CMD_DEPTH = 4;                 // Queue depth under test
   localparam int TIMEOUT   = 200;               // Cycles per wait loop

   logic           core_clk;
   logic           rst;
   logic           req;
   ycr_mem_cmd_e   cmd;
   ycr_mem_width_e width;
   logic [31:0]    addr;
   logic [31:0]    wdata;
   logic           req_ack;
   logic [31:0]    rdata;
   ycr_mem_resp_e  resp;
   logic           stb;
   logic           cyc;
   logic [31:0]    adr;
   logic           we;
   logic [31:0]    dat_o;
   logic [3:0]     sel;
   logic [31:0]    dat_i;
   logic           ack;
   logic           err;

   logic [31:0] slave_mem [64];                  // Slave storage indexed by adr[7:2]
   logic [31:0] model_mem [64];                  // Expected contents
   logic [34:0] resp_q [$];                      // {check data, resp, rdata}
   logic [68:0] bus_q  [$];                      // {we, sel, adr, dat}
   logic [15:0] lfsr;
   bit          long_waits;                      // Slow slave for back-pressure
   bit          saw_full;                        // req_ack seen low
   bit          in_cycle;
   int          wait_left;
   int          errors;
   int          checks;
   int          test_errs;
   int          stb_count;                       // Bus cycles started
   int          stb_before;
   int          chk_fails;

   ycr_intf #(
      .CMD_DEPTH (CMD_DEPTH)
   ) i_ycr_intf (
      .core_clk_i          (core_clk),
      .rst_i               (rst),
      .core_dmem_req_i     (req),
      .core_dmem_cmd_i     (cmd),
      .core_dmem_width_i   (width),
      .core_dmem_addr_i    (addr),
      .core_dmem_wdata_i   (wdata),
      .core_dmem_req_ack_o (req_ack),
      .core_dmem_rdata_o   (rdata),
      .core_dmem_resp_o    (resp),
      .wbd_dmem_stb_o      (stb),
      .wbd_dmem_cyc_o      (cyc),
      .wbd_dmem_adr_o      (adr),
      .wbd_dmem_we_o       (we),
      .wbd_dmem_dat_o      (dat_o),
      .wbd_dmem_sel_o      (sel),
      .wbd_dmem_dat_i      (dat_i),
      .wbd_dmem_ack_i      (ack),
      .wbd_dmem_err_i      (err)
   );

   always #5 core_clk = ~core_clk;               // 10 ns period

   //--------------------
   // Helpers
   //--------------------
   function automatic logic [31:0] fill_word(input int idx);
      return 32'hC0DE_0000 ^ (32'(idx) * 32'h0103_0507);   // Distinct per word
   endfunction

   // Galois LFSR with taps at 16 14 13 11
   function automatic int rand_bits(input int n);
      int v;
      v = 0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
         v    = (v << 1) | int'(lfsr[0]);
      end
      return v;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         test_errs++;
         $display("MISMATCH %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $finish;
   endtask

   task automatic next_cycle();
      @(posedge core_clk);
      #1;                                        // Drive after the edge
   endtask

   // Hold the request until accepted, then queue what must come back
   task automatic issue(input ycr_mem_cmd_e c, input ycr_mem_width_e w,
                        input logic [31:0] a, input logic [31:0] d);
      int          waited;
      logic [1:0]  off;
      logic [5:0]  idx;
      logic        bad;
      logic [3:0]  exp_sel;
      logic [31:0] exp_dat;
      waited = 0;
      off    = a[1:0];
      idx    = a[7:2];
      req    = 1'b1;
      cmd    = c;
      width  = w;
      addr   = a;
      wdata  = d;
      while (!req_ack) begin
         saw_full = 1'b1;
         next_cycle();
         waited++;
         if (waited > TIMEOUT) abort_run("Timeout waiting for request acceptance");
      end
      next_cycle();                              // Accepted at this edge
      req = 1'b0;
      case (w)
         MEM_WIDTH_BYTE: begin
            exp_sel = 4'b0001 << off;
            exp_dat = {4{d[7:0]}};
            bad     = 1'b0;
         end
         MEM_WIDTH_HWORD: begin
            exp_sel = off[1] ? 4'b1100 : 4'b0011;
            exp_dat = {2{d[15:0]}};
            bad     = off[0];
         end
         default: begin
            exp_sel = 4'b1111;
            exp_dat = d;
            bad     = (off != 2'd0);
         end
      endcase
      if (bad) begin
         resp_q.push_back({1'b0, MEM_RESP_RDY_ER, 32'h0});   // Never on the bus
      end else begin
         bus_q.push_back({c == MEM_CMD_WR, exp_sel, {a[31:2], 2'b00}, exp_dat});
         if (a[31:12] == 20'h1) begin
            resp_q.push_back({1'b0, MEM_RESP_RDY_ER, 32'h0});   // Error window
         end else begin
            if (c == MEM_CMD_WR) begin
               case (w)
                  MEM_WIDTH_BYTE:  model_mem[idx][8*off +: 8]  = d[7:0];
                  MEM_WIDTH_HWORD: model_mem[idx][8*off +: 16] = d[15:0];
                  default:         model_mem[idx] = d;
               endcase
            end
            resp_q.push_back({c == MEM_CMD_RD, MEM_RESP_RDY_OK, model_mem[idx]});
         end
      end
   endtask

   task automatic wait_responses();
      int waited;
      waited = 0;
      while (resp_q.size() != 0) begin
         next_cycle();
         waited++;
         if (waited > 4 * TIMEOUT) abort_run("Timeout waiting for outstanding responses");
      end
   endtask

   task automatic report_test(input int n, input string name);
      $display("Test %0d %s: %0d errors", n, name, test_errs);
      test_errs = 0;
   endtask

   //--------------------
   // Wishbone slave and response monitor
   //--------------------
   always @(posedge core_clk) begin : slave_model
      logic [68:0] exp_b;
      logic [5:0]  idx;
      #1;
      ack = 1'b0;
      err = 1'b0;
      if (rst) begin
         in_cycle = 1'b0;
      end else if (stb) begin
         if (!in_cycle) begin
            in_cycle  = 1'b1;
            stb_count++;
            wait_left = long_waits ? 6 + rand_bits(2) : rand_bits(2);
            if (bus_q.size() == 0) begin
               errors++;
               test_errs++;
               $display("Bus cycle started with no request outstanding");
            end else begin
               exp_b = bus_q.pop_front();
               check_value("wbd_dmem_we_o", 32'(we), 32'(exp_b[68]));
               check_value("wbd_dmem_sel_o", 32'(sel), 32'(exp_b[67:64]));
               check_value("wbd_dmem_adr_o", adr, exp_b[63:32]);
               if (we) check_value("wbd_dmem_dat_o", dat_o, exp_b[31:0]);
            end
         end
         if (wait_left == 0) begin
            in_cycle = 1'b0;
            idx      = adr[7:2];
            if (adr[31:12] == 20'h1) begin
               err = 1'b1;                       // Error window
            end else begin
               ack = 1'b1;
               for (int i = 0; i < 4; i++) begin
                  if (we && sel[i]) slave_mem[idx][8*i +: 8] = dat_o[8*i +: 8];
               end
            end
            dat_i = slave_mem[idx];
         end else begin
            wait_left--;
         end
      end
   end

   always @(posedge core_clk) begin : resp_monitor
      logic [34:0] exp_r;
      #1;
      if (!rst && resp != MEM_RESP_NOTRDY) begin
         if (resp_q.size() == 0) begin
            errors++;
            test_errs++;
            $display("Response with no request outstanding");
         end else begin
            exp_r = resp_q.pop_front();
            check_value("core_dmem_resp_o", 32'(resp), 32'(exp_r[33:32]));
            if (exp_r[34]) check_value("core_dmem_rdata_o", rdata, exp_r[31:0]);
         end
      end
   end

   //--------------------
   // Tests
   //--------------------
   initial begin
      core_clk   = 1'b0;
      rst        = 1'b1;
      req        = 1'b0;
      cmd        = MEM_CMD_RD;
      width      = MEM_WIDTH_WORD;
      addr       = '0;
      wdata      = '0;
      dat_i      = '0;
      ack        = 1'b0;
      err        = 1'b0;
      lfsr       = 16'd9;                        // Seed
      long_waits = 1'b0;
      for (int i = 0; i < 64; i++) begin
         slave_mem[i] = fill_word(i);
         model_mem[i] = fill_word(i);
      end
      repeat (4) @(posedge core_clk);            // Reset for 4 cycles
      #1;
      rst = 1'b0;

      issue(MEM_CMD_WR, MEM_WIDTH_WORD, 32'h10, 32'hDEAD_BEEF);
      issue(MEM_CMD_RD, MEM_WIDTH_WORD, 32'h10, 32'h0);
      wait_responses();
      report_test(1, "word write then read");

      for (int i = 0; i < 4; i++) begin
         issue(MEM_CMD_WR, MEM_WIDTH_BYTE, 32'h20 + i, 32'hA5A5_A500 | (32'h11 * (i + 1)));
      end
      issue(MEM_CMD_WR, MEM_WIDTH_HWORD, 32'h24, 32'h1234_BEEF);
      issue(MEM_CMD_WR, MEM_WIDTH_HWORD, 32'h26, 32'h5678_CAFE);
      issue(MEM_CMD_RD, MEM_WIDTH_WORD, 32'h20, 32'h0);
      issue(MEM_CMD_RD, MEM_WIDTH_WORD, 32'h24, 32'h0);
      issue(MEM_CMD_RD, MEM_WIDTH_BYTE, 32'h21, 32'h0);   // Raw word comes back
      wait_responses();
      report_test(2, "byte and halfword lanes");

      stb_before = stb_count;
      issue(MEM_CMD_WR, MEM_WIDTH_HWORD, 32'h31, 32'h0000_1111);
      issue(MEM_CMD_WR, MEM_WIDTH_WORD, 32'h32, 32'h2222_2222);
      issue(MEM_CMD_RD, MEM_WIDTH_WORD, 32'h33, 32'h0);
      issue(MEM_CMD_RD, MEM_WIDTH_HWORD, 32'h17, 32'h0);
      wait_responses();
      if (stb_count != stb_before) begin
         errors++;
         test_errs++;
         $display("Bus cycle seen for a misaligned access");
      end
      issue(MEM_CMD_RD, MEM_WIDTH_WORD, 32'h30, 32'h0);   // Memory left alone
      wait_responses();
      report_test(3, "misaligned accesses");

      issue(MEM_CMD_WR, MEM_WIDTH_WORD, 32'h1000, 32'h0BAD_0BAD);
      issue(MEM_CMD_RD, MEM_WIDTH_WORD, 32'h1004, 32'h0);
      issue(MEM_CMD_RD, MEM_WIDTH_WORD, 32'h0, 32'h0);    // Aliased word unchanged
      wait_responses();
      report_test(4, "error window");

      long_waits = 1'b1;
      saw_full   = 1'b0;
      for (int i = 0; i < CMD_DEPTH + 4; i++) begin
         if (i % 2 == 0) begin
            issue(MEM_CMD_WR, MEM_WIDTH_WORD, 32'h40 + 2 * i, 32'h600D_0000 + i);
         end else begin
            issue(MEM_CMD_RD, MEM_WIDTH_WORD, 32'h40 + 2 * (i - 1), 32'h0);
         end
      end
      wait_responses();
      if (!saw_full) begin
         errors++;
         test_errs++;
         $display("req_ack never dropped while the FIFO was full");
      end
      report_test(5, "back-pressure with slow slave");
      long_waits = 1'b0;

      chk_fails = i_ycr_intf.i_chk.fail_cnt;
      $display("Checks %0d, errors %0d, assertion failures %0d", checks, errors, chk_fails);
      if (errors == 0 && chk_fails == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule : tb_ycr_intf

//--- sim.f
common/ycr_intf_pkg.sv
dmem_wb/ycr_dmem_cmd_fifo.sv
dmem_wb/ycr_dmem_wb_master.sv
src/ycr_intf.sv
testbench/ycr_intf_chk.sv
testbench/tb_ycr_intf.sv

//--- Makefile
# Verilator build and run for the data memory bridge

VERILATOR ?= verilator
TOP       ?= tb_ycr_intf
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "Simulation finished: PASS" $(LOG); then \
		echo "Run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
